//--- sram_port_pkg.sv
// Shared widths, command encoding, queue geometry and entry offsets
// Queue depths must stay powers of two, as the FIFO pointers wrap freely
// The memory port addresses bytes, one full data word per transfer

package sram_port_pkg;

  // --------------------------------------------------------------------------
  // Bus widths
  // --------------------------------------------------------------------------
  localparam int addr_w     = 32;         // Byte address
  localparam int data_w     = 32;
  localparam int be_w       = data_w / 8; // One enable per byte
  localparam int index_w    = 24;         // Vertex index
  localparam int tag_w      = 8;
  localparam int cmd_w      = 2;
  localparam int word_shift = 2;          // Word index to byte address

  // Queue geometry
  localparam int req_fifo_depth       = 64;
  localparam int req_prog_thresh      = 32;
  localparam int inflight_depth       = 16;
  localparam int inflight_prog_thresh = 8;  // Leaves room for issued requests

  // Memory commands
  typedef enum logic [cmd_w-1:0] {
    cmd_read  = 2'b00,
    cmd_write = 2'b01
  } cmd_e;

  // --------------------------------------------------------------------------
  // Queue entry layout, metadata fields first
  // --------------------------------------------------------------------------
  localparam int cmd_lsb   = 0;
  localparam int tag_lsb   = cmd_lsb + cmd_w;
  localparam int index_lsb = tag_lsb + tag_w;
  localparam int meta_w    = index_lsb + index_w; // In-flight entry

  // Request queue adds the memory side payload above the metadata
  localparam int be_lsb      = meta_w;
  localparam int wdata_lsb   = be_lsb + be_w;
  localparam int addr_lsb    = wdata_lsb + data_w;
  localparam int req_entry_w = addr_lsb + addr_w;

endpackage : sram_port_pkg

//--- sync_fifo.sv
// First-word-fall-through queue, head word valid whenever empty_o is low
// depth must be a power of two
// Push while full and pop while empty are ignored

`timescale 1ns/1ps

module sync_fifo #(
  parameter int width       = 32,
  parameter int depth       = 16,
  parameter int prog_thresh = 8
) (
  input  logic             ap_clk,
  input  logic             areset_control,
  input  logic             push_i,
  input  logic [width-1:0] din_i,
  input  logic             pop_i,
  output logic [width-1:0] dout_o,
  output logic             empty_o,
  output logic             full_o,
  output logic             prog_full_o
);

  logic [width-1:0]             mem [depth]; // Storage, no reset
  logic [$clog2(depth)-1:0]     wr_ptr;
  logic [$clog2(depth)-1:0]     rd_ptr;
  logic [$clog2(depth + 1)-1:0] count;       // Entries held
  logic                         do_push;
  logic                         do_pop;

  assign do_push = push_i & ~full_o;  // Drop on overflow
  assign do_pop  = pop_i & ~empty_o;

  // --------------------------------------------------------------------------
  // Pointers and occupancy
  // --------------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1; // Wraps at depth
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge ap_clk) begin
    if (do_push) begin
      mem[wr_ptr] <= din_i;
    end
  end

  // Head word falls through
  assign dout_o = mem[rd_ptr];

  // Flags straight from the count
  assign empty_o     = (count == 0);
  assign full_o      = (count == depth);
  assign prog_full_o = (count >= prog_thresh);

endmodule : sync_fifo

//--- request_decode.sv
// Two register stages from packet input to request queue push
// The base address is taken at the second stage, so a descriptor must
// arrive before the first packet whose address depends on it

`timescale 1ns/1ps

module request_decode (
  input  logic                               ap_clk,
  input  logic                               areset_control,
  input  logic                               desc_valid_i,
  input  logic [sram_port_pkg::addr_w-1:0]   desc_base_i,
  input  logic                               req_valid_i,
  input  sram_port_pkg::cmd_e                req_cmd_i,
  input  logic [sram_port_pkg::index_w-1:0]  req_index_i,
  input  logic [sram_port_pkg::tag_w-1:0]    req_tag_i,
  input  logic [sram_port_pkg::data_w-1:0]   req_wdata_i,
  input  logic [sram_port_pkg::be_w-1:0]     req_be_i,
  output logic                               dec_push_o,
  output logic [sram_port_pkg::addr_w-1:0]   dec_addr_o,
  output sram_port_pkg::cmd_e                dec_cmd_o,
  output logic [sram_port_pkg::tag_w-1:0]    dec_tag_o,
  output logic [sram_port_pkg::index_w-1:0]  dec_index_o,
  output logic [sram_port_pkg::data_w-1:0]   dec_wdata_o,
  output logic [sram_port_pkg::be_w-1:0]     dec_be_o,
  output logic                               desc_loaded_o
);

  import sram_port_pkg::*;

  logic [addr_w-1:0]  desc_base_q;
  logic               s1_valid;     // First stage
  cmd_e               s1_cmd;
  logic [index_w-1:0] s1_index;
  logic [tag_w-1:0]   s1_tag;
  logic [data_w-1:0]  s1_wdata;
  logic [be_w-1:0]    s1_be;

  // --------------------------------------------------------------------------
  // Descriptor, held until reset
  // --------------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      desc_loaded_o <= 1'b0;
    end else if (desc_valid_i) begin
      desc_loaded_o <= 1'b1;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (desc_valid_i) begin
      desc_base_q <= desc_base_i;
    end
  end

  // Valid bits of both stages
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      s1_valid   <= 1'b0;
      dec_push_o <= 1'b0;
    end else begin
      s1_valid   <= req_valid_i;
      dec_push_o <= s1_valid;
    end
  end

  // Payload, second stage maps index to byte address
  always_ff @(posedge ap_clk) begin
    s1_cmd      <= req_cmd_i;
    s1_index    <= req_index_i;
    s1_tag      <= req_tag_i;
    s1_wdata    <= req_wdata_i;
    s1_be       <= req_be_i;
    dec_addr_o  <= desc_base_q + (addr_w'(s1_index) << word_shift);
    dec_cmd_o   <= s1_cmd;
    dec_tag_o   <= s1_tag;
    dec_index_o <= s1_index;
    dec_wdata_o <= s1_wdata;
    dec_be_o    <= (s1_cmd == cmd_write) ? s1_be : '0; // Reads carry no strobes
  end

endmodule : request_decode

//--- request_execute.sv
// Request queue and memory port drive
// mem_req_o is combinational from the queue head and may drop ungranted
// rsp_ready_i is sampled once, so it gates grants one cycle late

`timescale 1ns/1ps

module request_execute (
  input  logic                               ap_clk,
  input  logic                               areset_control,
  input  logic                               dec_push_i,
  input  logic [sram_port_pkg::addr_w-1:0]   dec_addr_i,
  input  sram_port_pkg::cmd_e                dec_cmd_i,
  input  logic [sram_port_pkg::tag_w-1:0]    dec_tag_i,
  input  logic [sram_port_pkg::index_w-1:0]  dec_index_i,
  input  logic [sram_port_pkg::data_w-1:0]   dec_wdata_i,
  input  logic [sram_port_pkg::be_w-1:0]     dec_be_i,
  input  logic                               desc_loaded_i,
  input  logic                               rsp_ready_i,
  input  logic                               inflight_stop_i,
  input  logic                               mem_gnt_i,
  output logic                               mem_req_o,
  output logic [sram_port_pkg::addr_w-1:0]   mem_addr_o,
  output logic                               mem_we_o,
  output logic [sram_port_pkg::data_w-1:0]   mem_wdata_o,
  output logic [sram_port_pkg::be_w-1:0]     mem_be_o,
  output logic                               issue_o,
  output sram_port_pkg::cmd_e                issue_cmd_o,
  output logic [sram_port_pkg::tag_w-1:0]    issue_tag_o,
  output logic [sram_port_pkg::index_w-1:0]  issue_index_o,
  output logic                               req_full_o,
  output logic                               req_prog_full_o,
  output logic                               req_empty_o
);

  import sram_port_pkg::*;

  logic [req_entry_w-1:0] req_din;
  logic [req_entry_w-1:0] req_head;
  logic                   q_full;
  logic                   q_prog_full;
  logic                   ready_q;   // Consumer ready, sampled

  assign req_din = {dec_addr_i, dec_wdata_i, dec_be_i, dec_index_i, dec_tag_i, dec_cmd_i};

  sync_fifo #(
    .width      (req_entry_w),
    .depth      (req_fifo_depth),
    .prog_thresh(req_prog_thresh)
  ) req_fifo_i (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .push_i        (dec_push_i),
    .din_i         (req_din),
    .pop_i         (issue_o),      // Granted head leaves
    .dout_o        (req_head),
    .empty_o       (req_empty_o),
    .full_o        (q_full),
    .prog_full_o   (q_prog_full)
  );

  // --------------------------------------------------------------------------
  // Issue gating
  // --------------------------------------------------------------------------
  assign mem_req_o = ~req_empty_o & desc_loaded_i & ready_q & ~inflight_stop_i;
  assign issue_o   = mem_req_o & mem_gnt_i;

  assign issue_cmd_o   = cmd_e'(req_head[cmd_lsb +: cmd_w]);
  assign issue_tag_o   = req_head[tag_lsb +: tag_w];
  assign issue_index_o = req_head[index_lsb +: index_w];

  // Memory side, strobes masked so an empty head drives none
  assign mem_addr_o  = req_head[addr_lsb +: addr_w];
  assign mem_wdata_o = req_head[wdata_lsb +: data_w];
  assign mem_we_o    = ~req_empty_o & (issue_cmd_o == cmd_write);
  assign mem_be_o    = req_head[be_lsb +: be_w] & {be_w{~req_empty_o}};

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      ready_q         <= 1'b0;
      req_full_o      <= 1'b0;
      req_prog_full_o <= 1'b0;
    end else begin
      ready_q         <= rsp_ready_i;
      req_full_o      <= q_full;      // Flags for the producer
      req_prog_full_o <= q_prog_full;
    end
  end

endmodule : request_execute

//--- response_result.sv
// In-flight metadata queue joined with memory responses
// Responses must return in issue order, one per granted transfer
// rsp_valid_o comes one cycle after mem_rsp_valid_i

`timescale 1ns/1ps

module response_result (
  input  logic                               ap_clk,
  input  logic                               areset_control,
  input  logic                               issue_i,
  input  sram_port_pkg::cmd_e                issue_cmd_i,
  input  logic [sram_port_pkg::tag_w-1:0]    issue_tag_i,
  input  logic [sram_port_pkg::index_w-1:0]  issue_index_i,
  input  logic                               mem_rsp_valid_i,
  input  logic [sram_port_pkg::data_w-1:0]   mem_rsp_rdata_i,
  output logic                               inflight_stop_o,
  output logic                               inflight_empty_o,
  output logic                               rsp_valid_o,
  output sram_port_pkg::cmd_e                rsp_cmd_o,
  output logic [sram_port_pkg::tag_w-1:0]    rsp_tag_o,
  output logic [sram_port_pkg::index_w-1:0]  rsp_index_o,
  output logic [sram_port_pkg::data_w-1:0]   rsp_data_o
);

  import sram_port_pkg::*;

  logic [meta_w-1:0] meta_head;  // Oldest outstanding request
  cmd_e              head_cmd;

  sync_fifo #(
    .width      (meta_w),
    .depth      (inflight_depth),
    .prog_thresh(inflight_prog_thresh)
  ) inflight_fifo_i (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .push_i        (issue_i),
    .din_i         ({issue_index_i, issue_tag_i, issue_cmd_i}),
    .pop_i         (mem_rsp_valid_i),
    .dout_o        (meta_head),
    .empty_o       (inflight_empty_o),
    .full_o        (),
    .prog_full_o   (inflight_stop_o)  // Stops issue well before full
  );

  assign head_cmd = cmd_e'(meta_head[cmd_lsb +: cmd_w]);

  // --------------------------------------------------------------------------
  // Response packet
  // --------------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      rsp_valid_o <= 1'b0;
    end else begin
      rsp_valid_o <= mem_rsp_valid_i & ~inflight_empty_o;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (mem_rsp_valid_i) begin
      rsp_cmd_o   <= head_cmd;
      rsp_tag_o   <= meta_head[tag_lsb +: tag_w];
      rsp_index_o <= meta_head[index_lsb +: index_w];
      rsp_data_o  <= (head_cmd == cmd_write) ? '0 : mem_rsp_rdata_i; // Writes return zero
    end
  end

endmodule : response_result

//--- sram_port_top.sv
// Memory request wrapper, packet in, request/grant memory port, packet out
// The producer must hold off while req_prog_full_o is high
// done_o covers the two queues only, not packets still in decode

`timescale 1ns/1ps

module sram_port_top (
  input  logic                               ap_clk,
  input  logic                               areset_control,
  // Descriptor
  input  logic                               desc_valid_i,
  input  logic [sram_port_pkg::addr_w-1:0]   desc_base_i,
  // Request packets
  input  logic                               req_valid_i,
  input  sram_port_pkg::cmd_e                req_cmd_i,
  input  logic [sram_port_pkg::index_w-1:0]  req_index_i,
  input  logic [sram_port_pkg::tag_w-1:0]    req_tag_i,
  input  logic [sram_port_pkg::data_w-1:0]   req_wdata_i,
  input  logic [sram_port_pkg::be_w-1:0]     req_be_i,
  output logic                               req_full_o,
  output logic                               req_prog_full_o,
  // Memory port
  output logic                               mem_req_o,
  output logic [sram_port_pkg::addr_w-1:0]   mem_addr_o,
  output logic                               mem_we_o,
  output logic [sram_port_pkg::data_w-1:0]   mem_wdata_o,
  output logic [sram_port_pkg::be_w-1:0]     mem_be_o,
  input  logic                               mem_gnt_i,
  input  logic                               mem_rsp_valid_i,
  input  logic [sram_port_pkg::data_w-1:0]   mem_rsp_rdata_i,
  // Response packets
  input  logic                               rsp_ready_i,
  output logic                               rsp_valid_o,
  output sram_port_pkg::cmd_e                rsp_cmd_o,
  output logic [sram_port_pkg::tag_w-1:0]    rsp_tag_o,
  output logic [sram_port_pkg::index_w-1:0]  rsp_index_o,
  output logic [sram_port_pkg::data_w-1:0]   rsp_data_o,
  output logic                               done_o
);

  import sram_port_pkg::*;

  logic               areset_q;      // Registered reset for all blocks
  logic               both_empty_q;
  // Decode to execute
  logic               dec_push;
  logic [addr_w-1:0]  dec_addr;
  cmd_e               dec_cmd;
  logic [tag_w-1:0]   dec_tag;
  logic [index_w-1:0] dec_index;
  logic [data_w-1:0]  dec_wdata;
  logic [be_w-1:0]    dec_be;
  logic               desc_loaded;
  // Execute to result
  logic               issue;
  cmd_e               issue_cmd;
  logic [tag_w-1:0]   issue_tag;
  logic [index_w-1:0] issue_index;
  logic               req_empty;
  logic               inflight_stop;
  logic               inflight_empty;

  // --------------------------------------------------------------------------
  // Reset and done flag
  // --------------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    areset_q <= areset_control;
  end

  always_ff @(posedge ap_clk) begin
    if (areset_q) begin
      both_empty_q <= 1'b0;
      done_o       <= 1'b0;
    end else begin
      both_empty_q <= req_empty & inflight_empty;
      done_o       <= both_empty_q;  // Two cycles behind the queues
    end
  end

  request_decode decode_i (
    .ap_clk        (ap_clk),
    .areset_control(areset_q),
    .desc_valid_i  (desc_valid_i),
    .desc_base_i   (desc_base_i),
    .req_valid_i   (req_valid_i),
    .req_cmd_i     (req_cmd_i),
    .req_index_i   (req_index_i),
    .req_tag_i     (req_tag_i),
    .req_wdata_i   (req_wdata_i),
    .req_be_i      (req_be_i),
    .dec_push_o    (dec_push),
    .dec_addr_o    (dec_addr),
    .dec_cmd_o     (dec_cmd),
    .dec_tag_o     (dec_tag),
    .dec_index_o   (dec_index),
    .dec_wdata_o   (dec_wdata),
    .dec_be_o      (dec_be),
    .desc_loaded_o (desc_loaded)
  );

  request_execute execute_i (
    .ap_clk         (ap_clk),
    .areset_control (areset_q),
    .dec_push_i     (dec_push),
    .dec_addr_i     (dec_addr),
    .dec_cmd_i      (dec_cmd),
    .dec_tag_i      (dec_tag),
    .dec_index_i    (dec_index),
    .dec_wdata_i    (dec_wdata),
    .dec_be_i       (dec_be),
    .desc_loaded_i  (desc_loaded),
    .rsp_ready_i    (rsp_ready_i),
    .inflight_stop_i(inflight_stop),
    .mem_gnt_i      (mem_gnt_i),
    .mem_req_o      (mem_req_o),
    .mem_addr_o     (mem_addr_o),
    .mem_we_o       (mem_we_o),
    .mem_wdata_o    (mem_wdata_o),
    .mem_be_o       (mem_be_o),
    .issue_o        (issue),
    .issue_cmd_o    (issue_cmd),
    .issue_tag_o    (issue_tag),
    .issue_index_o  (issue_index),
    .req_full_o     (req_full_o),
    .req_prog_full_o(req_prog_full_o),
    .req_empty_o    (req_empty)
  );

  response_result result_i (
    .ap_clk          (ap_clk),
    .areset_control  (areset_q),
    .issue_i         (issue),
    .issue_cmd_i     (issue_cmd),
    .issue_tag_i     (issue_tag),
    .issue_index_i   (issue_index),
    .mem_rsp_valid_i (mem_rsp_valid_i),
    .mem_rsp_rdata_i (mem_rsp_rdata_i),
    .inflight_stop_o (inflight_stop),
    .inflight_empty_o(inflight_empty),
    .rsp_valid_o     (rsp_valid_o),
    .rsp_cmd_o       (rsp_cmd_o),
    .rsp_tag_o       (rsp_tag_o),
    .rsp_index_o     (rsp_index_o),
    .rsp_data_o      (rsp_data_o)
  );

endmodule : sram_port_top

//--- sram_port_chk.sv
// Memory port protocol assertions, bound into request_execute
// fails counts assertion failures and is read by the testbench

`timescale 1ns/1ps

module sram_port_chk (
  input  logic                           ap_clk,
  input  logic                           areset_control,  // Registered copy
  input  logic                           mem_req_i,
  input  logic                           mem_we_i,
  input  logic [sram_port_pkg::be_w-1:0] mem_be_i
);

  int fails = 0;

  // Reads never carry strobes
  a_be_needs_we: assert property (@(posedge ap_clk) disable iff (areset_control)
    !mem_we_i |-> (mem_be_i == '0))
    else begin
      $error("mem_be_o nonzero while mem_we_o is low");
      fails++;
    end

  a_idle_after_reset: assert property (@(posedge ap_clk) areset_control |=> !mem_req_i)
    else begin
      $error("mem_req_o high in the cycle after reset");
      fails++;
    end

endmodule : sram_port_chk

bind request_execute sram_port_chk chk_i (
  .ap_clk        (ap_clk),
  .areset_control(areset_control),
  .mem_req_i     (mem_req_o),
  .mem_we_i      (mem_we_o),
  .mem_be_i      (mem_be_o)
);

//--- tb_sram_port.sv
// Random packet testbench for sram_port_top with its own memory and reference model
// Memory model grants at random and answers in order after 1 to 6 cycles
// Indices stay in 0..15 so reads often hit earlier writes
// Outputs are sampled on the falling edge, inputs change 1 ns after the rising edge

`timescale 1ns/1ps

module tb_sram_port;

  import sram_port_pkg::*;

  localparam int n_main    = 150;              // Packets per traffic test
  localparam int n_gate    = 8;                // Packets sent before the descriptor
  localparam int n_total   = 2 * n_main + n_gate;
  localparam int cyc_limit = 10 * n_total + 2000;

  logic               ap_clk;
  logic               areset_control;
  logic               desc_valid_i;
  logic [addr_w-1:0]  desc_base_i;
  logic               req_valid_i;
  cmd_e               req_cmd_i;
  logic [index_w-1:0] req_index_i;
  logic [tag_w-1:0]   req_tag_i;
  logic [data_w-1:0]  req_wdata_i;
  logic [be_w-1:0]    req_be_i;
  logic               req_full_o;
  logic               req_prog_full_o;
  logic               mem_req_o;
  logic [addr_w-1:0]  mem_addr_o;
  logic               mem_we_o;
  logic [data_w-1:0]  mem_wdata_o;
  logic [be_w-1:0]    mem_be_o;
  logic               mem_gnt_i;
  logic               mem_rsp_valid_i;
  logic [data_w-1:0]  mem_rsp_rdata_i;
  logic               rsp_ready_i;
  logic               rsp_valid_o;
  cmd_e               rsp_cmd_o;
  logic [tag_w-1:0]   rsp_tag_o;
  logic [index_w-1:0] rsp_index_o;
  logic [data_w-1:0]  rsp_data_o;
  logic               done_o;

  // Expected grants and responses, both in send order
  logic [addr_w-1:0]  exp_addr[$];
  logic               exp_we[$];
  logic [be_w-1:0]    exp_be[$];
  cmd_e               exp_rcmd[$];
  logic [tag_w-1:0]   exp_rtag[$];
  logic [index_w-1:0] exp_ridx[$];
  logic [data_w-1:0]  exp_rdata[$];

  logic [data_w-1:0]  ref_mem [logic [addr_w-1:0]];   // Reference contents
  logic [data_w-1:0]  mem_model [logic [addr_w-1:0]]; // Memory behind the port
  int                 rsp_due[$];                      // Cycle each response goes out
  logic [data_w-1:0]  rsp_word[$];

  int                 cycle;
  int                 last_due;
  logic [addr_w-1:0]  base;
  logic               ready_prev;  // rsp_ready_i one sample back
  logic               gate_watch;  // No requests allowed
  logic [tag_w-1:0]   next_tag;
  int                 q_cnt;        // Request queue occupancy model
  logic [2:0]         push_pipe;    // Sent packets on their way into the queue
  logic               pop_prev;     // Grant one sample back
  int                 inflight_cnt; // Granted, not yet answered by the memory
  string              cur_test;
  int                 test_errs;
  int                 total_errs;
  int                 tests_run;
  int                 tests_failed;

  sram_port_top dut_i (.*);

  initial begin
    ap_clk = 1'b0;
    forever #4 ap_clk = ~ap_clk;
  end

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------
  function automatic logic [data_w-1:0] fill_word(input logic [addr_w-1:0] addr);
    return addr ^ 32'h6b3d_a419;  // Unwritten words
  endfunction

  function automatic logic [data_w-1:0] merge_bytes(input logic [data_w-1:0] old_w,
                                                    input logic [data_w-1:0] new_w,
                                                    input logic [be_w-1:0]   be);
    logic [data_w-1:0] res;
    res = old_w;
    for (int b = 0; b < be_w; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  task automatic log_mismatch(input string what, input logic [31:0] exp_v,
                              input logic [31:0] act_v);
    $display("Error %s %s expected 0x%08h actual 0x%08h", cur_test, what, exp_v, act_v);
    test_errs++;
  endtask

  task automatic log_failure(input string what);
    $display("Failure in %s: %s", cur_test, what);
    test_errs++;
  endtask

  task automatic begin_test(input string name);
    total_errs += test_errs;  // Failures seen between tests
    cur_test  = name;
    test_errs = 0;
  endtask

  task automatic finish_test();
    tests_run++;
    total_errs += test_errs;
    if (test_errs == 0) begin
      $display("PASS %s", cur_test);
    end else begin
      $display("FAIL %s with %0d errors", cur_test, test_errs);
      tests_failed++;
    end
    test_errs = 0;
  endtask

  task automatic apply_reset();
    @(posedge ap_clk);
    #1;
    areset_control = 1'b1;
    repeat (10) @(posedge ap_clk);
    #1;
    areset_control = 1'b0;
  endtask

  task automatic load_desc(input logic [addr_w-1:0] b);
    @(posedge ap_clk);
    #1;
    desc_valid_i = 1'b1;
    desc_base_i  = b;
    gate_watch   = 1'b0;  // Requests may start from here
    @(posedge ap_clk);
    #1;
    desc_valid_i = 1'b0;
  endtask

  // One random packet on the inputs, reference model updated in send order
  task automatic send_packet();
    cmd_e               cmd;
    logic [index_w-1:0] idx;
    logic [data_w-1:0]  wd;
    logic [be_w-1:0]    be;
    logic [addr_w-1:0]  addr;
    logic [data_w-1:0]  old_w;
    cmd   = ($urandom_range(0, 1) == 1) ? cmd_write : cmd_read;
    idx   = index_w'($urandom_range(0, 15));
    wd    = $urandom();
    be    = be_w'($urandom());  // Reads get random enables too
    addr  = base + 4 * addr_w'(idx);
    req_valid_i = 1'b1;
    req_cmd_i   = cmd;
    req_index_i = idx;
    req_tag_i   = next_tag;
    req_wdata_i = wd;
    req_be_i    = be;
    old_w = ref_mem.exists(addr) ? ref_mem[addr] : fill_word(addr);
    exp_addr.push_back(addr);
    exp_we.push_back(cmd == cmd_write);
    exp_be.push_back((cmd == cmd_write) ? be : '0);
    exp_rcmd.push_back(cmd);
    exp_rtag.push_back(next_tag);
    exp_ridx.push_back(idx);
    if (cmd == cmd_write) begin
      ref_mem[addr] = merge_bytes(old_w, wd, be);
      exp_rdata.push_back('0);
    end else begin
      exp_rdata.push_back(old_w);
    end
    next_tag = next_tag + 1'b1;
  endtask

  task automatic send_packets(input int n, input bit toggle_ready);
    int sent;
    sent = 0;
    while (sent < n) begin
      @(posedge ap_clk);
      #1;
      req_valid_i = 1'b0;
      if (toggle_ready && $urandom_range(0, 7) == 0) begin
        rsp_ready_i = ~rsp_ready_i;  // Random ready runs
      end
      if (!req_prog_full_o && $urandom_range(0, 1) == 1) begin
        send_packet();
        sent++;
      end
    end
    @(posedge ap_clk);
    #1;
    req_valid_i = 1'b0;
  endtask

  // Wait for every expected response, the watchdog bounds this
  task automatic drain();
    rsp_ready_i = 1'b1;
    while (exp_rcmd.size() != 0) begin
      @(posedge ap_clk);
    end
  endtask

  // --------------------------------------------------------------------------
  // Memory model and checks on the port
  // --------------------------------------------------------------------------
  task automatic check_grant();
    logic [data_w-1:0] old_w;
    int                delay;
    if (exp_addr.size() == 0) begin
      log_failure("grant with no request outstanding");
    end else begin
      if (mem_addr_o !== exp_addr[0]) begin
        log_mismatch("mem_addr_o", exp_addr[0], mem_addr_o);
      end
      if (mem_we_o !== exp_we[0]) begin
        log_mismatch("mem_we_o", exp_we[0], mem_we_o);
      end
      if (mem_be_o !== exp_be[0]) begin
        log_mismatch("mem_be_o", exp_be[0], mem_be_o);
      end
      void'(exp_addr.pop_front());
      void'(exp_we.pop_front());
      void'(exp_be.pop_front());
    end
    if (!ready_prev) begin
      log_failure("grant while rsp_ready_i was low");
    end
    if (inflight_cnt >= inflight_prog_thresh) begin
      log_failure("grant while the in-flight queue was at its stop level");
    end
    old_w = mem_model.exists(mem_addr_o) ? mem_model[mem_addr_o] : fill_word(mem_addr_o);
    if (mem_we_o) begin
      mem_model[mem_addr_o] = merge_bytes(old_w, mem_wdata_o, mem_be_o);
    end
    delay    = $urandom_range(1, 6);
    last_due = (cycle + delay > last_due) ? cycle + delay : last_due + 1; // Keep order
    rsp_due.push_back(last_due);
    rsp_word.push_back(old_w);  // Writes return stale data too
  endtask

  task automatic check_response();
    if (exp_rcmd.size() == 0) begin
      log_failure("response with none expected");
    end else begin
      if (rsp_cmd_o !== exp_rcmd[0]) begin
        log_mismatch("rsp_cmd_o", exp_rcmd[0], rsp_cmd_o);
      end
      if (rsp_tag_o !== exp_rtag[0]) begin
        log_mismatch("rsp_tag_o", exp_rtag[0], rsp_tag_o);
      end
      if (rsp_index_o !== exp_ridx[0]) begin
        log_mismatch("rsp_index_o", exp_ridx[0], rsp_index_o);
      end
      if (rsp_data_o !== exp_rdata[0]) begin
        log_mismatch("rsp_data_o", exp_rdata[0], rsp_data_o);
      end
      void'(exp_rcmd.pop_front());
      void'(exp_rtag.pop_front());
      void'(exp_ridx.pop_front());
      void'(exp_rdata.pop_front());
    end
  endtask

  // Flags are registered, so they show the occupancy one edge back
  task automatic check_queue_flags();
    if (req_full_o !== (q_cnt == req_fifo_depth)) begin
      log_mismatch("req_full_o", q_cnt == req_fifo_depth, req_full_o);
    end
    if (req_prog_full_o !== (q_cnt >= req_prog_thresh)) begin
      log_mismatch("req_prog_full_o", q_cnt >= req_prog_thresh, req_prog_full_o);
    end
  endtask

  // A sent packet reaches the queue three edges after it is driven
  task automatic track_queues();
    logic push_now;
    push_now = push_pipe[2] && (q_cnt != req_fifo_depth);  // Lost when full
    if (push_now) begin
      q_cnt++;
    end
    if (pop_prev) begin
      q_cnt--;
    end
    push_pipe = {push_pipe[1:0], req_valid_i};
    pop_prev  = mem_req_o && mem_gnt_i;
    if (mem_req_o && mem_gnt_i) begin
      inflight_cnt++;
    end
    if (mem_rsp_valid_i) begin
      inflight_cnt--;
    end
  endtask

  always @(negedge ap_clk) begin
    if (!areset_control) begin
      if (gate_watch && mem_req_o) begin
        log_failure("mem_req_o high before the descriptor was loaded");
      end
      check_queue_flags();
      if (mem_req_o && mem_gnt_i) begin
        check_grant();
      end
      if (rsp_valid_o) begin
        check_response();
      end
      ready_prev = rsp_ready_i;
      track_queues();
    end else begin
      q_cnt        = 0;
      push_pipe    = '0;
      pop_prev     = 1'b0;
      inflight_cnt = 0;
    end
  end

  // Grant and response drive, plus the watchdog
  always @(posedge ap_clk) begin
    cycle = cycle + 1;
    if (cycle >= cyc_limit) begin
      $display("Timeout after %0d cycles in %s with %0d responses missing",
               cycle, cur_test, exp_rcmd.size());
      $display("Test failures found");
      $finish;
    end else begin
      #1;
      mem_gnt_i = ($urandom_range(0, 3) != 0);
      if (rsp_due.size() != 0 && rsp_due[0] <= cycle) begin
        mem_rsp_valid_i = 1'b1;
        mem_rsp_rdata_i = rsp_word.pop_front();
        void'(rsp_due.pop_front());
      end else begin
        mem_rsp_valid_i = 1'b0;
        mem_rsp_rdata_i = '0;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------
  initial begin
    void'($urandom(32'h9d970cac));
    areset_control  = 1'b1;
    desc_valid_i    = 1'b0;
    desc_base_i     = '0;
    req_valid_i     = 1'b0;
    req_cmd_i       = cmd_read;
    req_index_i     = '0;
    req_tag_i       = '0;
    req_wdata_i     = '0;
    req_be_i        = '0;
    mem_gnt_i       = 1'b0;
    mem_rsp_valid_i = 1'b0;
    mem_rsp_rdata_i = '0;
    rsp_ready_i     = 1'b1;
    cycle           = 0;
    last_due        = 0;
    ready_prev      = 1'b1;
    gate_watch      = 1'b0;
    next_tag        = '0;
    test_errs       = 0;
    total_errs      = 0;
    tests_run       = 0;
    tests_failed    = 0;
    cur_test        = "reset";
    base            = $urandom() & 32'hffff_fffc;  // Word aligned

    apply_reset();
    load_desc(base);

    begin_test("addr_data");
    send_packets(n_main, 1'b0);
    drain();
    finish_test();

    begin_test("back_pressure");
    send_packets(n_main, 1'b1);
    drain();
    finish_test();

    // Reset clears the loaded flag, packets must wait in the queue
    begin_test("desc_gating");
    apply_reset();
    gate_watch = 1'b1;
    send_packets(n_gate, 1'b0);
    repeat (30) @(posedge ap_clk);
    load_desc(base);
    drain();
    finish_test();

    begin_test("done_flag");
    repeat (2) @(posedge ap_clk);
    #1;
    if (done_o !== 1'b1) begin
      log_mismatch("done_o", 32'd1, done_o);
    end
    finish_test();

    begin_test("assertions");
    if (dut_i.execute_i.chk_i.fails != 0) begin
      log_failure("concurrent assertions on the memory port failed");
    end
    finish_test();

    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errs);
    if (tests_failed == 0 && total_errs == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule : tb_sram_port

//--- all.f
sram_port_pkg.sv
sync_fifo.sv
request_decode.sv
request_execute.sv
response_result.sv
sram_port_top.sv
sram_port_chk.sv
tb_sram_port.sv

//--- Bender.yml
package:
  name: sram_port

sources:
  - sram_port_pkg.sv
  - sync_fifo.sv
  - request_decode.sv
  - request_execute.sv
  - response_result.sv
  - sram_port_top.sv
  - target: test
    files:
      - sram_port_chk.sv
      - tb_sram_port.sv
